/* filelist.f */
cart_bus_pkg.sv
cart_quirk_pkg.sv
ioctl_intake.sv
cart_region_scan.sv
region_select.sv
cart_quirk_match.sv
cheat_code_loader.sv
cart_loader_top.sv
tb_cart_loader.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cartridge loader testbench with Verilator.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_cart_loader -f filelist.f -o sim_cart_loader
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_cart_loader > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
	echo "no pass line found in $LOG"
	exit 1
fi
exit 0

/* tb_cart_loader.sv */
/*
 Testbench for the cartridge loader. Each table row is one full download.
 Cart rows write 0x000 to 0x200 while a ROM responder acknowledges each request.
 Cheat rows write eight words at offsets 0 to 14 with the cheat menu index.
 Acknowledge delay and filler bytes come from $urandom with a fixed seed.
*/
`timescale 1ns/1ps

module tb_cart_loader
	import cart_bus_pkg::*;
	import cart_quirk_pkg::*;
;

	localparam int ADDR_W = 25;
	localparam int NUM_ROWS = 18;
	localparam int SEED = 29780;
	localparam int TIMEOUT_CYCLES = NUM_ROWS * 257 * 10 + 1000;
	localparam logic [1:0] KIND_CART = 2'd0;
	localparam logic [1:0] KIND_CHEAT_ON = 2'd1;
	localparam logic [1:0] KIND_CHEAT_OFF = 2'd2;
	// error categories
	localparam int CAT_RESET = 0;
	localparam int CAT_ROM = 1;
	localparam int CAT_REGION = 2;
	localparam int CAT_QUIRK = 3;
	localparam int CAT_CHEAT = 4;

	// one download with its expected results
	typedef struct packed {
		logic [1:0]  kind;
		logic [1:0]  mode;
		logic [1:0]  prio;
		logic [7:0]  index;
		logic [23:0] hdr;
		logic [63:0] serial;
		logic [1:0]  exp_region;
		logic        exp_set;
		logic [7:0]  exp_quirk;
		logic        exp_gun;
		logic [7:0]  exp_delay;
	} row_t;

	logic                   clk_sys;
	logic                   RESET;
	logic                   ioctl_download;
	logic                   ioctl_wr;
	logic [ADDR_W-1:0]      ioctl_addr;
	logic [DATA_W-1:0]      ioctl_data;
	logic [7:0]             ioctl_index;
	logic                   ioctl_wait;
	logic                   rom_req;
	logic                   rom_ack;
	logic [ADDR_W-2:0]      rom_addr;
	logic [DATA_W-1:0]      rom_wdata;
	auto_region_t           region_mode;
	region_prio_t           region_prio;
	logic                   cheat_en;
	logic [1:0]             region_req;
	logic                   region_set;
	logic [QUIRK_COUNT-1:0] quirk_flags;
	logic                   gun_type;
	gun_delay_t             gun_sensor_delay;
	logic [127:0]           code_word;
	logic                   code_stb;
	logic                   code_reset;

	row_t              rows [NUM_ROWS];
	int                error_count [5];
	int                total_errors;
	int                cycle_count = 0;
	int                writes_sent = 0;
	int                acks_served = 0;
	int                stb_count = 0;
	int                reset_count = 0;
	logic              exp_req;
	logic [ADDR_W-2:0] exp_addr_q [$];
	logic [DATA_W-1:0] exp_data_q [$];

	cart_loader_top #(.ADDR_W(ADDR_W)) dut_i (
		.clk_sys(clk_sys), .RESET(RESET), .ioctl_download(ioctl_download),
		.ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data),
		.ioctl_index(ioctl_index), .ioctl_wait(ioctl_wait), .rom_req(rom_req),
		.rom_ack(rom_ack), .rom_addr(rom_addr), .rom_wdata(rom_wdata),
		.region_mode(region_mode), .region_prio(region_prio), .cheat_en(cheat_en),
		.region_req(region_req), .region_set(region_set), .quirk_flags(quirk_flags),
		.gun_type(gun_type), .gun_sensor_delay(gun_sensor_delay),
		.code_word(code_word), .code_stb(code_stb), .code_reset(code_reset)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// strobe counters, sampled mid-cycle
	always @(negedge clk_sys) begin
		if (code_stb) stb_count++;
		if (code_reset) reset_count++;
	end

	// run length guard
	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display("Simulation FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	task automatic note_error(input int cat, input string msg);
		$display("Error at time %0t: %s", $time, msg);
		error_count[cat]++;
	endtask

	function automatic logic [7:0] quirk_mask(input quirk_kind_t k);
		return 8'(1) << k;
	endfunction

	// header byte at byte address a, serial at 0x183..0x18A, letters at 0x1F0..0x1F2
	function automatic logic [7:0] header_byte(input row_t r, input int a);
		if ((a >= 'h183) && (a <= 'h18A)) return r.serial[63 - 8 * (a - 'h183) -: 8];
		if ((a >= HDR_REGION_ADDR_LO) && (a <= HDR_REGION_ADDR_LO + 2)) begin
			return r.hdr[23 - 8 * (a - HDR_REGION_ADDR_LO) -: 8];
		end
		// filler elsewhere
		return 8'($urandom);
	endfunction

	// plays ROM memory, one acknowledge per request after 0 to 5 cycles
	task automatic serve_rom();
		int                delay;
		logic [ADDR_W-2:0] want_addr;
		logic [DATA_W-1:0] want_data;
		forever begin
			@(posedge clk_sys);
			#1;
			if (!RESET && (rom_req != rom_ack)) begin
				acks_served++;
				if (exp_addr_q.size() == 0) begin
					note_error(CAT_ROM, "ROM request without a cartridge write");
				end else begin
					want_addr = exp_addr_q.pop_front();
					want_data = exp_data_q.pop_front();
					assert (rom_addr == want_addr) else note_error(CAT_ROM,
						$sformatf("rom_addr %h, expected %h", rom_addr, want_addr));
					assert (rom_wdata == want_data) else note_error(CAT_ROM,
						$sformatf("rom_wdata %h, expected %h", rom_wdata, want_data));
				end
				delay = $urandom_range(5, 0);
				repeat (delay) begin
					assert (ioctl_wait) else note_error(CAT_ROM, "ioctl_wait fell before ack");
					@(posedge clk_sys);
					#1;
				end
				rom_ack = rom_req;
			end
		end
	endtask

	// one host write, entered and left 1 ns after a rising edge
	task automatic write_word(input int a, input logic [DATA_W-1:0] data, input bit is_cart);
		assert (!ioctl_wait) else note_error(CAT_ROM, "write attempted while ioctl_wait high");
		if (is_cart) begin
			exp_addr_q.push_back((ADDR_W-1)'(a >> 1));
			exp_data_q.push_back({data[7:0], data[15:8]});
			exp_req = ~exp_req;
			writes_sent++;
		end
		ioctl_addr = ADDR_W'(a);
		ioctl_data = data;
		ioctl_wr   = 1'b1;
		@(posedge clk_sys);
		#1;
		ioctl_wr = 1'b0;
		if (is_cart) begin
			assert (rom_req == exp_req) else note_error(CAT_ROM, "rom_req did not toggle");
			assert (ioctl_wait) else note_error(CAT_ROM, "ioctl_wait did not rise");
			// back-pressure, hold off until memory catches up
			while (ioctl_wait) begin
				@(posedge clk_sys);
				#1;
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// downloads
	////////////////////////////////////////////////////////////

	task automatic run_cart(input int i);
		row_t r;
		r = rows[i];
		region_mode    = auto_region_t'(r.mode);
		region_prio    = region_prio_t'(r.prio);
		ioctl_index    = r.index;
		ioctl_download = 1'b1;
		@(posedge clk_sys);
		#1;
		for (int a = 0; a <= HDR_END_ADDR; a += 2) begin
			write_word(a, {header_byte(r, a + 1), header_byte(r, a)}, 1'b1);
		end
		// region result lands two cycles after the 0x200 write
		repeat (3) @(posedge clk_sys);
		#1;
		assert ((region_req == r.exp_region) && (region_set == r.exp_set)) else
			note_error(CAT_REGION, $sformatf("row %0d region %0d set %0b, expected %0d set %0b",
				i, region_req, region_set, r.exp_region, r.exp_set));
		assert (quirk_flags == r.exp_quirk) else note_error(CAT_QUIRK,
			$sformatf("row %0d quirk_flags %h, expected %h", i, quirk_flags, r.exp_quirk));
		assert ((gun_type == r.exp_gun) && (gun_sensor_delay == r.exp_delay)) else
			note_error(CAT_QUIRK, $sformatf("row %0d gun %0b/%0d, expected %0b/%0d",
				i, gun_type, gun_sensor_delay, r.exp_gun, r.exp_delay));
		ioctl_download = 1'b0;
		repeat (3) @(posedge clk_sys);
		#1;
		assert (!region_set) else note_error(CAT_REGION, $sformatf("row %0d region_set held", i));
		assert ((writes_sent == acks_served) && (exp_addr_q.size() == 0)) else
			note_error(CAT_ROM, $sformatf("row %0d writes %0d, requests %0d",
				i, writes_sent, acks_served));
	endtask

	task automatic run_cheat(input int i);
		logic [DATA_W-1:0] words [8];
		logic [127:0]      exp_code;
		int                stb_before;
		int                reset_before;
		int                acks_before;
		stb_before     = stb_count;
		reset_before   = reset_count;
		acks_before    = acks_served;
		cheat_en       = (rows[i].kind == KIND_CHEAT_ON);
		ioctl_index    = rows[i].index;
		ioctl_download = 1'b1;
		@(posedge clk_sys);
		#1;
		for (int k = 0; k < 8; k++) begin
			words[k] = 16'($urandom);
			write_word(2 * k, words[k], 1'b0);
		end
		repeat (3) @(posedge clk_sys);
		#1;
		// flags, address, compare, replace with the high word on top
		exp_code = {words[1], words[0], words[3], words[2],
			words[5], words[4], words[7], words[6]};
		assert (code_word == exp_code) else note_error(CAT_CHEAT,
			$sformatf("row %0d code_word %h, expected %h", i, code_word, exp_code));
		assert (stb_count - stb_before == int'(cheat_en)) else note_error(CAT_CHEAT,
			$sformatf("row %0d code_stb pulses %0d", i, stb_count - stb_before));
		assert (reset_count - reset_before == 1) else note_error(CAT_CHEAT,
			$sformatf("row %0d code_reset pulses %0d", i, reset_count - reset_before));
		assert (acks_served == acks_before) else note_error(CAT_ROM, "ROM request on cheat load");
		ioctl_download = 1'b0;
		repeat (2) @(posedge clk_sys);
		#1;
	endtask

	// region letters, serial and expected results per download
	task automatic fill_table();
		rows[0]  = '{KIND_CART, by_header, us_eu_jp, 8'h00, "JUE", "T-081276",
			us, 1'b1, quirk_mask(sram), 1'b0, 8'd44};
		rows[1]  = '{KIND_CART, by_header, eu_us_jp, 8'h00, "J  ", "MK-1215 ",
			jp, 1'b1, quirk_mask(eeprom), 1'b0, 8'd44};
		rows[2]  = '{KIND_CART, by_header, us_jp_eu, 8'h00, "E 4", "T-113016",
			eu, 1'b1, quirk_mask(noram), 1'b0, 8'd44};
		// no letters falls back to the first of the order
		rows[3]  = '{KIND_CART, by_header, us_eu_jp, 8'h00, "   ", "T-89016 ",
			us, 1'b1, quirk_mask(fifo), 1'b0, 8'd44};
		rows[4]  = '{KIND_CART, by_header, eu_us_jp, 8'h00, "  U", "T-574023",
			us, 1'b1, quirk_mask(pier), 1'b0, 8'd44};
		rows[5]  = '{KIND_CART, by_file_ext, us_eu_jp, 8'h81, "JUE", "MK-1229 ",
			eu, 1'b1, quirk_mask(svp), 1'b0, 8'd44};
		rows[6]  = '{KIND_CART, by_file_ext, us_eu_jp, 8'h40, "JUE", "T-35036 ",
			us, 1'b1, quirk_mask(fmbusy), 1'b0, 8'd44};
		// disabled keeps the region of row 6
		rows[7]  = '{KIND_CART, disabled, us_eu_jp, 8'h00, "J  ", "T-68???-",
			us, 1'b0, quirk_mask(schan), 1'b0, 8'd44};
		rows[8]  = '{KIND_CART, by_file_ext, us_eu_jp, 8'h00, "JUE", "MK-1533 ",
			jp, 1'b0, 8'h00, 1'b0, 8'd100};
		rows[9]  = '{KIND_CART, by_header, us_eu_jp, 8'h00, "1JU", "T-95096-",
			us, 1'b1, 8'h00, 1'b1, 8'd52};
		rows[10] = '{KIND_CART, by_header, jp_us_eu, 8'h00, "EU ", "T-95136-",
			us, 1'b1, 8'h00, 1'b1, 8'd30};
		// lower case j is outside 0 to Z
		rows[11] = '{KIND_CART, by_header, us_jp_eu, 8'h00, "jJ?", "MK-1658 ",
			jp, 1'b1, 8'h00, 1'b0, 8'd120};
		rows[12] = '{KIND_CART, by_header, eu_us_jp, 8'h00, "ZJ[", "T-081156",
			eu, 1'b1, 8'h00, 1'b0, 8'd126};
		rows[13] = '{KIND_CART, by_header, us_eu_jp, 8'h00, "JJJ", "T-00000 ",
			jp, 1'b1, 8'h00, 1'b0, 8'd44};
		// second serial of the sram and eeprom entries
		rows[14] = '{KIND_CART, by_header, jp_us_eu, 8'h00, "UE ", "T-81406 ",
			us, 1'b1, quirk_mask(sram), 1'b0, 8'd44};
		rows[15] = '{KIND_CART, by_header, us_jp_eu, 8'h00, "EJ ", "T-12046 ",
			jp, 1'b1, quirk_mask(eeprom), 1'b0, 8'd44};
		rows[16] = '{KIND_CHEAT_ON, disabled, us_eu_jp, CODE_INDEX, "   ", "        ",
			jp, 1'b0, 8'h00, 1'b0, 8'd44};
		rows[17] = '{KIND_CHEAT_OFF, disabled, us_eu_jp, CODE_INDEX, "   ", "        ",
			jp, 1'b0, 8'h00, 1'b0, 8'd44};
	endtask

	initial begin
		serve_rom();
	end

	initial begin
		void'($urandom(SEED));
		RESET          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_data     = '0;
		ioctl_index    = 8'h00;
		rom_ack        = 1'b0;
		region_mode    = disabled;
		region_prio    = us_eu_jp;
		cheat_en       = 1'b0;
		exp_req        = 1'b0;
		for (int c = 0; c < 5; c++) error_count[c] = 0;
		fill_table();
		repeat (10) @(posedge clk_sys);
		#1;
		assert (!ioctl_wait && !rom_req && !region_set && !code_stb && !code_reset &&
			(quirk_flags == '0)) else note_error(CAT_RESET, "control outputs not low in reset");
		assert (gun_sensor_delay == 8'd44) else note_error(CAT_RESET,
			$sformatf("gun_sensor_delay %0d in reset, expected 44", gun_sensor_delay));
		RESET = 1'b0;
		@(posedge clk_sys);
		#1;
		for (int i = 0; i < NUM_ROWS; i++) begin
			if (rows[i].kind == KIND_CART) run_cart(i);
			else run_cheat(i);
		end
		total_errors = 0;
		for (int c = 0; c < 5; c++) total_errors += error_count[c];
		$display("Error counts: reset %0d, rom %0d, region %0d, quirk %0d, cheat %0d, total %0d",
			error_count[CAT_RESET], error_count[CAT_ROM], error_count[CAT_REGION],
			error_count[CAT_QUIRK], error_count[CAT_CHEAT], total_errors);
		if (total_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* cart_loader_top.sv */
/*
 Cartridge loading side of the console core.
 ADDR_W sets the host address width for every block.
 One clock and one synchronous reset serve the whole loader.
*/
`timescale 1ns/1ps

module cart_loader_top
	import cart_bus_pkg::*;
	import cart_quirk_pkg::*;
#(
	parameter int ADDR_W = 25
) (
	input  logic                   clk_sys,
	input  logic                   RESET,
	// host download bus
	input  logic                   ioctl_download,
	input  logic                   ioctl_wr,
	input  logic [ADDR_W-1:0]      ioctl_addr,
	input  logic [DATA_W-1:0]      ioctl_data,
	input  logic [7:0]             ioctl_index,
	output logic                   ioctl_wait,
	// rom memory write port
	output logic                   rom_req,
	input  logic                   rom_ack,
	output logic [ADDR_W-2:0]      rom_addr,
	output logic [DATA_W-1:0]      rom_wdata,
	// user options
	input  auto_region_t           region_mode,
	input  region_prio_t           region_prio,
	input  logic                   cheat_en,
	// results for the core
	output logic [1:0]             region_req,
	output logic                   region_set,
	output logic [QUIRK_COUNT-1:0] quirk_flags,
	output logic                   gun_type,
	output gun_delay_t             gun_sensor_delay,
	output logic [127:0]           code_word,
	output logic                   code_stb,
	output logic                   code_reset
);

	logic cart_download;
	logic cart_wr;
	logic code_wr;
	logic hdr_j;
	logic hdr_u;
	logic hdr_e;
	logic hdr_ready;

	ioctl_intake #(.ADDR_W(ADDR_W)) intake_i (
		.clk_sys(clk_sys), .RESET(RESET),
		.ioctl_download(ioctl_download), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data), .ioctl_index(ioctl_index),
		.rom_ack(rom_ack), .cart_download(cart_download), .cart_wr(cart_wr),
		.code_wr(code_wr), .ioctl_wait(ioctl_wait), .rom_req(rom_req),
		.rom_addr(rom_addr), .rom_wdata(rom_wdata)
	);

	// header region letters
	cart_region_scan #(.ADDR_W(ADDR_W)) scan_i (
		.clk_sys(clk_sys), .RESET(RESET), .cart_download(cart_download),
		.cart_wr(cart_wr), .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data),
		.hdr_j(hdr_j), .hdr_u(hdr_u), .hdr_e(hdr_e), .hdr_ready(hdr_ready)
	);

	region_select select_i (
		.clk_sys(clk_sys), .RESET(RESET), .hdr_j(hdr_j), .hdr_u(hdr_u),
		.hdr_e(hdr_e), .hdr_ready(hdr_ready), .region_mode(region_mode),
		.region_prio(region_prio), .ioctl_index(ioctl_index),
		.region_req(region_req), .region_set(region_set)
	);

	cart_quirk_match #(.ADDR_W(ADDR_W)) quirk_i (
		.clk_sys(clk_sys), .RESET(RESET), .cart_download(cart_download),
		.cart_wr(cart_wr), .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data),
		.quirk_flags(quirk_flags), .gun_type(gun_type),
		.gun_sensor_delay(gun_sensor_delay)
	);

	// cheat downloads only
	cheat_code_loader #(.ADDR_W(ADDR_W)) cheat_i (
		.clk_sys(clk_sys), .RESET(RESET), .code_wr(code_wr),
		.ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data), .cheat_en(cheat_en),
		.code_word(code_word), .code_stb(code_stb), .code_reset(code_reset)
	);

endmodule

/* cheat_code_loader.sv */
/*
 Cheat code assembly from eight 16-bit words at offsets 0 to 14.
 code_word is {flags, address, compare, replace}, each 32 bits, high field first.
 Values pass through in host order and the cheat engine sorts out byte order.
 code_stb fires after offset 14 only with cheat_en high.
*/
`timescale 1ns/1ps

module cheat_code_loader
	import cart_bus_pkg::*;
#(
	parameter int ADDR_W = 25
) (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              code_wr,
	input  logic [ADDR_W-1:0] ioctl_addr,
	input  logic [DATA_W-1:0] ioctl_data,
	input  logic              cheat_en,
	output logic [127:0]      code_word,
	output logic              code_stb,
	output logic              code_reset
);

	// word slot within one 16-byte code record
	typedef enum logic [3:0] {
		flags_lo   = 4'd0,
		flags_hi   = 4'd2,
		addr_lo    = 4'd4,
		addr_hi    = 4'd6,
		compare_lo = 4'd8,
		compare_hi = 4'd10,
		replace_lo = 4'd12,
		replace_hi = 4'd14
	} code_slot_t;

	code_slot_t slot;

	assign slot = code_slot_t'(ioctl_addr[3:0]);

	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (slot)
				flags_lo:   code_word[111:96]  <= ioctl_data;
				flags_hi:   code_word[127:112] <= ioctl_data;
				addr_lo:    code_word[79:64]   <= ioctl_data;
				addr_hi:    code_word[95:80]   <= ioctl_data;
				compare_lo: code_word[47:32]   <= ioctl_data;
				compare_hi: code_word[63:48]   <= ioctl_data;
				replace_lo: code_word[15:0]    <= ioctl_data;
				replace_hi: code_word[31:16]   <= ioctl_data;
				// odd offsets never come from the host
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			code_stb   <= 1'b0;
			code_reset <= 1'b0;
		end else begin
			// last word completes the record
			code_stb   <= code_wr && (slot == replace_hi) && cheat_en;
			// a new cheat file flushes the stored codes
			code_reset <= code_wr && (ioctl_addr == '0);
		end
	end

	// one host write per word gives one strobe per code
	code_stb_single: assert property (
		@(posedge clk_sys) disable iff (RESET) code_stb |=> !code_stb
	) else $error("code_stb held longer than one cycle");

endmodule

/* cart_quirk_match.sv */
/*
 Serial number capture and quirk lookup from the cartridge header.
 The serial is bytes 0x183 to 0x18A and is matched on the write to 0x18C.
 Quirk flags clear at the start of each cart download.
 Unknown serials get gun type 0 and the default sensor delay.
*/
`timescale 1ns/1ps

module cart_quirk_match
	import cart_bus_pkg::*;
	import cart_quirk_pkg::*;
#(
	parameter int ADDR_W = 25
) (
	input  logic                   clk_sys,
	input  logic                   RESET,
	input  logic                   cart_download,
	input  logic                   cart_wr,
	input  logic [ADDR_W-1:0]      ioctl_addr,
	input  logic [DATA_W-1:0]      ioctl_data,
	output logic [QUIRK_COUNT-1:0] quirk_flags,
	output logic                   gun_type,
	output gun_delay_t             gun_sensor_delay
);

	// serial field words inside the header
	localparam int ID_ADDR_0  = 'h182;
	localparam int ID_ADDR_1  = 'h184;
	localparam int ID_ADDR_2  = 'h186;
	localparam int ID_ADDR_3  = 'h188;
	localparam int ID_ADDR_4  = 'h18A;
	localparam int MATCH_ADDR = 'h18C;

	logic [CART_ID_W-1:0] cart_id;
	logic                 dl_d;
	logic                 match_wr;

	////////////////////////////////////////////////////////////
	// lookup tables
	////////////////////////////////////////////////////////////

	function automatic logic [QUIRK_COUNT-1:0] quirk_lookup(input logic [CART_ID_W-1:0] id);
		logic [QUIRK_COUNT-1:0] q;
		q = '0;
		case (id)
			// sports titles with odd sram mapping
			"T-081276", "T-81406 ": q[sram] = 1'b1;
			// eeprom saves
			"MK-1215 ", "T-12046 ": q[eeprom] = 1'b1;
			"T-113016": q[noram] = 1'b1;
			"T-89016 ": q[fifo] = 1'b1;
			"T-574023": q[pier] = 1'b1;
			"MK-1229 ": q[svp] = 1'b1;
			"T-35036 ": q[fmbusy] = 1'b1;
			"T-68???-": q[schan] = 1'b1;
			default: q = '0;
		endcase
		return q;
	endfunction

	// {gun type, sensor delay} for the light-gun titles
	function automatic logic [8:0] gun_lookup(input logic [CART_ID_W-1:0] id);
		logic [8:0] g;
		case (id)
			"MK-1533 ": g = {1'b0, 8'd100};
			// justifier pair
			"T-95096-": g = {1'b1, 8'd52};
			"T-95136-": g = {1'b1, 8'd30};
			"MK-1658 ": g = {1'b0, 8'd120};
			"T-081156": g = {1'b0, 8'd126};
			default:    g = {1'b0, GUN_DELAY_DEFAULT};
		endcase
		return g;
	endfunction

	////////////////////////////////////////////////////////////
	// serial capture
	////////////////////////////////////////////////////////////

	// low data byte comes first in header order
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			case (ioctl_addr)
				ADDR_W'(ID_ADDR_0): cart_id[63:56] <= ioctl_data[15:8];
				ADDR_W'(ID_ADDR_1): cart_id[55:40] <= {ioctl_data[7:0], ioctl_data[15:8]};
				ADDR_W'(ID_ADDR_2): cart_id[39:24] <= {ioctl_data[7:0], ioctl_data[15:8]};
				ADDR_W'(ID_ADDR_3): cart_id[23:8]  <= {ioctl_data[7:0], ioctl_data[15:8]};
				ADDR_W'(ID_ADDR_4): cart_id[7:0]   <= ioctl_data[7:0];
				default: begin
				end
			endcase
		end
	end

	// serial is complete by the time 0x18C arrives
	assign match_wr = cart_wr && (ioctl_addr == ADDR_W'(MATCH_ADDR));

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_d             <= 1'b0;
			quirk_flags      <= '0;
			gun_type         <= 1'b0;
			gun_sensor_delay <= GUN_DELAY_DEFAULT;
		end else begin
			dl_d <= cart_download;
			if (cart_download && !dl_d) begin
				quirk_flags <= '0;
			end else if (match_wr) begin
				quirk_flags                  <= quirk_lookup(cart_id);
				{gun_type, gun_sensor_delay} <= gun_lookup(cart_id);
			end
		end
	end

endmodule

/* region_select.sv */
/*
 Console region choice, taken once on the rise of hdr_ready.
 Header mode walks the priority order and falls back to its first region.
 File-extension mode takes the region from menu index bits 7:6.
 region_set drops when hdr_ready falls.
*/
`timescale 1ns/1ps

module region_select
	import cart_bus_pkg::*;
(
	input  logic         clk_sys,
	input  logic         RESET,
	input  logic         hdr_j,
	input  logic         hdr_u,
	input  logic         hdr_e,
	input  logic         hdr_ready,
	input  auto_region_t region_mode,
	input  region_prio_t region_prio,
	input  logic [7:0]   ioctl_index,
	output logic [1:0]   region_req,
	output logic         region_set
);

	logic ready_d;
	logic ready_rise;
	logic ready_fall;

	// first region of the order that the header lists
	// have is indexed by region code
	function automatic region_t pick_region(input region_prio_t prio, input logic [2:0] have);
		region_t order [3];
		region_t pick;
		case (prio)
			us_eu_jp: order = '{us, eu, jp};
			eu_us_jp: order = '{eu, us, jp};
			us_jp_eu: order = '{us, jp, eu};
			default:  order = '{jp, us, eu};
		endcase
		pick = order[0];
		// walk backwards so the earliest present entry wins
		for (int i = 2; i >= 0; i--) begin
			if (have[order[i]]) begin
				pick = order[i];
			end
		end
		return pick;
	endfunction

	assign ready_rise = hdr_ready & ~ready_d;
	assign ready_fall = ~hdr_ready & ready_d;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ready_d    <= 1'b0;
			region_req <= jp;
			region_set <= 1'b0;
		end else begin
			ready_d <= hdr_ready;
			if (ready_rise) begin
				case (region_mode)
					by_header: begin
						region_set <= 1'b1;
						region_req <= pick_region(region_prio, {hdr_e, hdr_u, hdr_j});
					end
					by_file_ext: begin
						// index zero means no extension hint
						region_set <= |ioctl_index;
						region_req <= ioctl_index[7:6];
					end
					// disabled keeps the last choice
					default: begin
					end
				endcase
			end else if (ready_fall) begin
				region_set <= 1'b0;
			end
		end
	end

endmodule

/* cart_region_scan.sv */
/*
 Cartridge header region scan. Letters are taken from both bytes of 0x1F0
 and from the low byte of 0x1F2. Flags clear at the start of each cart download.
 hdr_ready rises with the write to 0x200 and falls when the download ends.
*/
`timescale 1ns/1ps

module cart_region_scan
	import cart_bus_pkg::*;
#(
	parameter int ADDR_W = 25
) (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              cart_download,
	input  logic              cart_wr,
	input  logic [ADDR_W-1:0] ioctl_addr,
	input  logic [DATA_W-1:0] ioctl_data,
	output logic              hdr_j,
	output logic              hdr_u,
	output logic              hdr_e
	,output logic             hdr_ready
);

	logic       dl_d;
	logic       dl_rise;
	logic       dl_fall;
	logic       at_lo;
	logic       at_hi;
	logic       at_end;
	logic [2:0] lo_hits;
	logic [2:0] hi_hits;

	// one header byte as {e, u, j}
	// anything printable from 0 to Z other than J or U counts as europe
	function automatic logic [2:0] letter_hits(input logic [7:0] c);
		logic [2:0] hits;
		hits = 3'b000;
		if (c == "J") begin
			hits = 3'b001;
		end else if (c == "U") begin
			hits = 3'b010;
		end else if ((c >= "0") && (c <= "Z")) begin
			hits = 3'b100;
		end
		return hits;
	endfunction

	assign dl_rise = cart_download & ~dl_d;
	assign dl_fall = ~cart_download & dl_d;

	// write decodes
	assign at_lo  = cart_wr && (ioctl_addr == ADDR_W'(HDR_REGION_ADDR_LO));
	assign at_hi  = cart_wr && (ioctl_addr == ADDR_W'(HDR_REGION_ADDR_HI));
	assign at_end = cart_wr && (ioctl_addr == ADDR_W'(HDR_END_ADDR));

	// same rule for both bytes of the first word
	assign lo_hits = letter_hits(ioctl_data[15:8]) | letter_hits(ioctl_data[7:0]);
	assign hi_hits = letter_hits(ioctl_data[7:0]);

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_d      <= 1'b0;
			hdr_j     <= 1'b0;
			hdr_u     <= 1'b0;
			hdr_e     <= 1'b0;
			hdr_ready <= 1'b0;
		end else begin
			dl_d <= cart_download;

			// flags accumulate over the two region words
			if (dl_rise) begin
				{hdr_e, hdr_u, hdr_j} <= 3'b000;
			end else if (at_lo) begin
				{hdr_e, hdr_u, hdr_j} <= {hdr_e, hdr_u, hdr_j} | lo_hits;
			end else if (at_hi) begin
				{hdr_e, hdr_u, hdr_j} <= {hdr_e, hdr_u, hdr_j} | hi_hits;
			end

			if (dl_fall) begin
				hdr_ready <= 1'b0;
			end else if (at_end) begin
				hdr_ready <= 1'b1;
			end
		end
	end

endmodule

/* ioctl_intake.sv */
/*
 Host download intake. Splits cart and cheat downloads and forwards cart words.
 rom_req toggles once per cart word and memory answers by copying it to rom_ack.
 The host must hold ioctl_wr low while ioctl_wait is high.
 rom_addr is the word address and rom_wdata has its two bytes swapped.
*/
`timescale 1ns/1ps

module ioctl_intake
	import cart_bus_pkg::*;
#(
	parameter int ADDR_W = 25
) (
	input  logic              clk_sys,
	input  logic              RESET,
	input  logic              ioctl_download,
	input  logic              ioctl_wr,
	input  logic [ADDR_W-1:0] ioctl_addr,
	input  logic [DATA_W-1:0] ioctl_data,
	input  logic [7:0]        ioctl_index,
	input  logic              rom_ack,
	output logic              cart_download,
	output logic              cart_wr,
	output logic              code_wr,
	output logic              ioctl_wait,
	output logic              rom_req,
	output logic [ADDR_W-2:0] rom_addr,
	output logic [DATA_W-1:0] rom_wdata
);

	logic code_sel;

	// download type from the menu index
	assign code_sel      = (ioctl_index == CODE_INDEX);
	assign cart_download = ioctl_download & ~code_sel;
	// strobes follow the host write in the same cycle
	assign cart_wr       = cart_download & ioctl_wr;
	assign code_wr       = ioctl_download & code_sel & ioctl_wr;

	// request toggle and host back-pressure
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ioctl_wait <= 1'b0;
			rom_req    <= 1'b0;
		end else if (cart_wr) begin
			ioctl_wait <= 1'b1;
			rom_req    <= ~rom_req;
		end else if (ioctl_wait && (rom_ack == rom_req)) begin
			// memory caught up with the last toggle
			ioctl_wait <= 1'b0;
		end
	end

	// word address and byte-swapped data held for memory
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			rom_addr  <= ioctl_addr[ADDR_W-1:1];
			rom_wdata <= {ioctl_data[DATA_W/2-1:0], ioctl_data[DATA_W-1:DATA_W/2]};
		end
	end

	// a write during wait would overrun the pending request
	host_wait_respected: assert property (
		@(posedge clk_sys) disable iff (RESET) ioctl_wait |-> !ioctl_wr
	) else $error("ioctl_wr high while ioctl_wait is high");

endmodule

/* cart_quirk_pkg.sv */
/*
 Cartridge quirk and light-gun definitions.
 Quirk kinds double as bit positions in the quirk flag vector.
 The serial number is eight ASCII characters with the first one in the top byte.
*/
package cart_quirk_pkg;

	// one flag per kind of cartridge special case
	typedef enum logic [2:0] {
		// save ram mapped outside the header rules
		sram   = 3'd0,
		// serial eeprom save instead of sram
		eeprom = 3'd1,
		// cart probes for ram that must stay absent
		noram  = 3'd2,
		// fast vdp fifo timing
		fifo   = 3'd3,
		// pier solar mapper
		pier   = 3'd4,
		// svp coprocessor cart
		svp    = 3'd5,
		// fm busy flag emulation
		fmbusy = 3'd6,
		// compilation cart with its own sound channel handling
		schan  = 3'd7
	} quirk_kind_t;

	localparam int QUIRK_COUNT = 8;

	// eight serial characters
	localparam int CART_ID_W = 64;

	// light-gun sensor delay in pixel clocks
	typedef logic [7:0] gun_delay_t;

	localparam gun_delay_t GUN_DELAY_DEFAULT = 8'd44;

endpackage

/* cart_bus_pkg.sv */
/*
 Host download bus definitions shared by the cartridge loader blocks.
 Addresses are byte addresses, so every 16-bit word sits at an even value.
 The low data byte is the even header byte and the high data byte the odd one.
 A cheat download is recognised only by its all-ones menu index.
*/
package cart_bus_pkg;

	// host data word, two header bytes per write
	localparam int DATA_W = 16;

	// menu index that the host uses for cheat files
	localparam logic [7:0] CODE_INDEX = 8'hFF;

	////////////////////////////////////////////////////////////
	// cartridge header layout
	////////////////////////////////////////////////////////////

	// first region word holds two letters
	localparam int HDR_REGION_ADDR_LO = 'h1F0;
	// second region word holds one letter in its low byte
	localparam int HDR_REGION_ADDR_HI = 'h1F2;
	// first word past the header
	localparam int HDR_END_ADDR = 'h200;

	////////////////////////////////////////////////////////////
	// region selection
	////////////////////////////////////////////////////////////

	// console region code as the core expects it
	typedef enum logic [1:0] {
		jp = 2'd0,
		us = 2'd1,
		eu = 2'd2
	} region_t;

	// search order when the header lists several regions
	typedef enum logic [1:0] {
		us_eu_jp = 2'd0,
		eu_us_jp = 2'd1,
		us_jp_eu = 2'd2,
		jp_us_eu = 2'd3
	} region_prio_t;

	// source of the automatic region choice
	// code 3 acts like disabled
	typedef enum logic [1:0] {
		by_file_ext = 2'd0,
		by_header   = 2'd1,
		disabled    = 2'd2
	} auto_region_t;

endpackage
